//--- rv_pkg.sv
// rv64i subset types and codes where both memory sizes must be powers of two
package rv_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  imm_kind_t;
  typedef logic [2:0]  mem_op_t;
  typedef logic [2:0]  branch_t;
  typedef logic [1:0]  b_src_t;

  typedef enum logic [3:0] {
    ALU_COPY_B = 4'b0011, // lui
    ALU_ADD    = 4'b0000,
    ALU_ADDW   = 4'b1001, // add then sign extend bit 31
    ALU_SUB    = 4'b1000,
    ALU_NONE   = 4'b1111
  } alu_op_e;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_IMM32  = 7'b0011011;
  localparam logic [6:0] OP_OP32   = 7'b0111011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam imm_kind_t IMM_I    = 3'b000;
  localparam imm_kind_t IMM_U    = 3'b001;
  localparam imm_kind_t IMM_S    = 3'b010;
  localparam imm_kind_t IMM_B    = 3'b011;
  localparam imm_kind_t IMM_J    = 3'b100;
  localparam imm_kind_t IMM_NONE = 3'b111; // r-type and unknown

  localparam mem_op_t MEM_W    = 3'b100; // signed word
  localparam mem_op_t MEM_D    = 3'b110; // signed doubleword
  localparam mem_op_t MEM_NONE = 3'b111;

  localparam branch_t BR_NONE = 3'b000;
  localparam branch_t BR_JAL  = 3'b001;
  localparam branch_t BR_JALR = 3'b010;
  localparam branch_t BR_BNE  = 3'b101;

  localparam b_src_t BSRC_RS2  = 2'b00;
  localparam b_src_t BSRC_IMM  = 2'b01;
  localparam b_src_t BSRC_FOUR = 2'b10; // return address pc+4

  localparam int IMEM_WORDS = 256; // 32-bit words
  localparam int DMEM_WORDS = 256; // 64-bit doublewords
  localparam int IMEM_AW    = 8;
  localparam int DMEM_AW    = 8;

endpackage

//--- rv_alu.sv
// combinational 64-bit alu with copy add addw and sub where zero flags an all-zero result
module rv_alu (
  input  rv_pkg::xlen_t   i_a,
  input  rv_pkg::xlen_t   i_b,
  input  rv_pkg::alu_op_e i_op,
  output rv_pkg::xlen_t   o_result,
  output logic            o_zero
);

  rv_pkg::xlen_t sum;
  rv_pkg::xlen_t diff;

  assign sum  = i_a + i_b;
  assign diff = i_a - i_b;

  always_comb begin
    case (i_op)
      rv_pkg::ALU_COPY_B: o_result = i_b;
      rv_pkg::ALU_ADD:    o_result = sum;
      rv_pkg::ALU_ADDW:   o_result = {{32{sum[31]}}, sum[31:0]}; // wraps at 32 bits
      rv_pkg::ALU_SUB:    o_result = diff;
      default:            o_result = '0;
    endcase
  end

  // bne uses this with sub
  assign o_zero = (o_result == '0);

endmodule

//--- rv_idu.sv
// decodes only lui auipc jal jalr bne lw sw sd addi addiw addw ebreak and zeroes all writes otherwise
module rv_idu (
  input  rv_pkg::inst_t    i_inst,
  output rv_pkg::xlen_t    o_imm,
  output rv_pkg::reg_idx_t o_ra,
  output rv_pkg::reg_idx_t o_rb,
  output rv_pkg::reg_idx_t o_rd,
  output rv_pkg::branch_t  o_branch,
  output logic             o_reg_wr,
  output logic             o_alu_a_src,
  output rv_pkg::b_src_t   o_alu_b_src,
  output rv_pkg::alu_op_e  o_alu_op,
  output logic             o_mem_to_reg,
  output logic             o_mem_wr,
  output rv_pkg::mem_op_t  o_mem_op,
  output logic             o_ebreak
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_pkg::imm_kind_t imm_kind;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_ra   = i_inst[19:15];
  assign o_rb   = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  always_comb begin
    imm_kind     = rv_pkg::IMM_NONE;
    o_branch     = rv_pkg::BR_NONE;
    o_reg_wr     = 1'b0;
    o_alu_a_src  = 1'b0;
    o_alu_b_src  = rv_pkg::BSRC_RS2;
    o_alu_op     = rv_pkg::ALU_NONE;
    o_mem_to_reg = 1'b0;
    o_mem_wr     = 1'b0;
    o_mem_op     = rv_pkg::MEM_NONE;
    o_ebreak     = 1'b0;
    case (opcode)
      rv_pkg::OP_LUI: begin
        imm_kind    = rv_pkg::IMM_U;
        o_reg_wr    = 1'b1;
        o_alu_b_src = rv_pkg::BSRC_IMM;
        o_alu_op    = rv_pkg::ALU_COPY_B;
      end
      rv_pkg::OP_AUIPC: begin
        imm_kind    = rv_pkg::IMM_U;
        o_reg_wr    = 1'b1;
        o_alu_a_src = 1'b1;
        o_alu_b_src = rv_pkg::BSRC_IMM;
        o_alu_op    = rv_pkg::ALU_ADD;
      end
      rv_pkg::OP_JAL: begin
        imm_kind    = rv_pkg::IMM_J;
        o_branch    = rv_pkg::BR_JAL;
        o_reg_wr    = 1'b1;
        o_alu_a_src = 1'b1;
        o_alu_b_src = rv_pkg::BSRC_FOUR;
        o_alu_op    = rv_pkg::ALU_ADD;
      end
      rv_pkg::OP_JALR: begin
        if (funct3 == 3'b000) begin
          imm_kind    = rv_pkg::IMM_I;
          o_branch    = rv_pkg::BR_JALR;
          o_reg_wr    = 1'b1;
          o_alu_a_src = 1'b1;
          o_alu_b_src = rv_pkg::BSRC_FOUR;
          o_alu_op    = rv_pkg::ALU_ADD;
        end
      end
      rv_pkg::OP_BRANCH: begin
        if (funct3 == 3'b001) begin // bne only
          imm_kind = rv_pkg::IMM_B;
          o_branch = rv_pkg::BR_BNE;
          o_alu_op = rv_pkg::ALU_SUB;
        end
      end
      rv_pkg::OP_LOAD: begin
        if (funct3 == 3'b010) begin
          imm_kind     = rv_pkg::IMM_I;
          o_reg_wr     = 1'b1;
          o_alu_b_src  = rv_pkg::BSRC_IMM;
          o_alu_op     = rv_pkg::ALU_ADD;
          o_mem_to_reg = 1'b1;
          o_mem_op     = rv_pkg::MEM_W;
        end
      end
      rv_pkg::OP_STORE: begin
        if (funct3 == 3'b010 || funct3 == 3'b011) begin
          imm_kind    = rv_pkg::IMM_S;
          o_alu_b_src = rv_pkg::BSRC_IMM;
          o_alu_op    = rv_pkg::ALU_ADD;
          o_mem_wr    = 1'b1;
          o_mem_op    = funct3[0] ? rv_pkg::MEM_D : rv_pkg::MEM_W; // sd : sw
        end
      end
      rv_pkg::OP_IMM, rv_pkg::OP_IMM32: begin
        if (funct3 == 3'b000) begin
          imm_kind    = rv_pkg::IMM_I;
          o_reg_wr    = 1'b1;
          o_alu_b_src = rv_pkg::BSRC_IMM;
          o_alu_op    = (opcode == rv_pkg::OP_IMM32) ? rv_pkg::ALU_ADDW : rv_pkg::ALU_ADD;
        end
      end
      rv_pkg::OP_OP32: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          o_reg_wr = 1'b1;
          o_alu_op = rv_pkg::ALU_ADDW;
        end
      end
      rv_pkg::OP_SYSTEM: begin
        // full ebreak encoding, no csr forms
        o_ebreak = (i_inst[31:20] == 12'h001) && (i_inst[19:7] == 13'd0);
      end
      default: ;
    endcase
  end

  always_comb begin
    case (imm_kind)
      rv_pkg::IMM_I: o_imm = {{52{i_inst[31]}}, i_inst[31:20]};
      rv_pkg::IMM_U: o_imm = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
      rv_pkg::IMM_S: o_imm = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      rv_pkg::IMM_B: o_imm = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
      rv_pkg::IMM_J: o_imm = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
      default:       o_imm = '0;
    endcase
  end

endmodule

//--- rv_regfile.sv
// 32 x 64 registers with asynchronous reads and x0 held at zero by reset and ignored writes
module rv_regfile (
  input  logic             i_clk,
  input  logic             i_rst,
  input  rv_pkg::reg_idx_t i_ra,
  input  rv_pkg::reg_idx_t i_rb,
  input  rv_pkg::reg_idx_t i_dbg_ra,
  input  rv_pkg::reg_idx_t i_rd,
  input  logic             i_wr_en,
  input  rv_pkg::xlen_t    i_wr_data,
  output rv_pkg::xlen_t    o_rdata_a,
  output rv_pkg::xlen_t    o_rdata_b,
  output rv_pkg::xlen_t    o_dbg_rdata
);

  rv_pkg::xlen_t regs [32];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr_en && (i_rd != '0)) begin
      regs[i_rd] <= i_wr_data;
    end
  end

  assign o_rdata_a   = regs[i_ra];
  assign o_rdata_b   = regs[i_rb];
  assign o_dbg_rdata = regs[i_dbg_ra]; // testbench peek

endmodule

//--- rv_pcu.sv
// pc and halt flag where an ebreak freezes the pc on its own address until reset
module rv_pcu (
  input  logic            i_clk,
  input  logic            i_rst,
  input  rv_pkg::branch_t i_branch,
  input  rv_pkg::xlen_t   i_imm,
  input  rv_pkg::xlen_t   i_rs1,
  input  logic            i_zero,
  input  logic            i_ebreak,
  output rv_pkg::xlen_t   o_pc,
  output logic            o_halt
);

  rv_pkg::xlen_t pc_q;
  rv_pkg::xlen_t pc_next;
  logic          halt_q;

  always_comb begin
    case (i_branch)
      rv_pkg::BR_JAL:  pc_next = pc_q + i_imm;
      rv_pkg::BR_JALR: pc_next = (i_rs1 + i_imm) & ~64'd1;
      rv_pkg::BR_BNE:  pc_next = i_zero ? pc_q + 64'd4 : pc_q + i_imm;
      default:         pc_next = pc_q + 64'd4;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q   <= '0;
      halt_q <= 1'b0;
    end else if (!halt_q) begin
      if (i_ebreak) begin
        halt_q <= 1'b1; // pc stays on the ebreak
      end else begin
        pc_q <= pc_next;
      end
    end
  end

  assign o_pc   = pc_q;
  assign o_halt = halt_q;

endmodule

//--- rv_dmem.sv
// doubleword data memory with word or doubleword access and address bits above the array ignored
module rv_dmem (
  input  logic            i_clk,
  input  logic            i_wr_en,
  input  rv_pkg::xlen_t   i_addr,
  input  rv_pkg::xlen_t   i_wdata,
  input  rv_pkg::mem_op_t i_mem_op,
  output rv_pkg::xlen_t   o_rdata
);

  rv_pkg::xlen_t mem [rv_pkg::DMEM_WORDS];

  logic [rv_pkg::DMEM_AW-1:0] idx;
  logic [31:0]                word;

  assign idx = i_addr[rv_pkg::DMEM_AW+2:3];

  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      case (i_mem_op)
        rv_pkg::MEM_D: mem[idx] <= i_wdata;
        rv_pkg::MEM_W: begin
          if (i_addr[2]) begin
            mem[idx][63:32] <= i_wdata[31:0];
          end else begin
            mem[idx][31:0] <= i_wdata[31:0];
          end
        end
        default: ;
      endcase
    end
  end

  assign word = i_addr[2] ? mem[idx][63:32] : mem[idx][31:0]; // half picked by bit 2

  always_comb begin
    case (i_mem_op)
      rv_pkg::MEM_W: o_rdata = {{32{word[31]}}, word};
      rv_pkg::MEM_D: o_rdata = mem[idx];
      default:       o_rdata = '0;
    endcase
  end

endmodule

//--- rv_imem.sv
// instruction memory loaded through its write port with fetch using pc bits 9 to 2 only
module rv_imem (
  input  logic                       i_clk,
  input  logic                       i_load_we,
  input  logic [rv_pkg::IMEM_AW-1:0] i_load_addr,
  input  rv_pkg::inst_t              i_load_data,
  input  rv_pkg::xlen_t              i_pc,
  output rv_pkg::inst_t              o_inst
);

  rv_pkg::inst_t mem [rv_pkg::IMEM_WORDS];

  always_ff @(posedge i_clk) begin
    if (i_load_we) begin
      mem[i_load_addr] <= i_load_data;
    end
  end

  // word index, low two pc bits dropped
  assign o_inst = mem[i_pc[rv_pkg::IMEM_AW+1:2]];

endmodule

//--- rv_core.sv
// single-cycle rv64i subset core whose program must be loaded during reset before it runs
module rv_core (
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_load_we,
  input  logic [rv_pkg::IMEM_AW-1:0] i_load_addr,
  input  rv_pkg::inst_t              i_load_data,
  input  rv_pkg::reg_idx_t           i_dbg_ra,
  output rv_pkg::xlen_t              o_dbg_rdata,
  output rv_pkg::xlen_t              o_pc,
  output logic                       o_halt
);

  rv_pkg::inst_t    inst;
  rv_pkg::xlen_t    pc;
  rv_pkg::xlen_t    imm;
  rv_pkg::reg_idx_t ra;
  rv_pkg::reg_idx_t rb;
  rv_pkg::reg_idx_t rd;
  rv_pkg::branch_t  branch;
  rv_pkg::b_src_t   alu_b_src;
  rv_pkg::alu_op_e  alu_op;
  rv_pkg::mem_op_t  mem_op;
  rv_pkg::xlen_t    rs1;
  rv_pkg::xlen_t    rs2;
  rv_pkg::xlen_t    alu_a;
  rv_pkg::xlen_t    alu_b;
  rv_pkg::xlen_t    alu_result;
  rv_pkg::xlen_t    load_data;
  rv_pkg::xlen_t    wb_data;
  logic             reg_wr;
  logic             alu_a_src;
  logic             mem_to_reg;
  logic             mem_wr;
  logic             ebreak;
  logic             zero;
  logic             halt;
  logic             wr_ok;

  rv_imem u_imem (
    .i_clk(i_clk), .i_load_we(i_load_we), .i_load_addr(i_load_addr),
    .i_load_data(i_load_data), .i_pc(pc), .o_inst(inst)
  );

  rv_idu u_idu (
    .i_inst(inst), .o_imm(imm), .o_ra(ra), .o_rb(rb), .o_rd(rd),
    .o_branch(branch), .o_reg_wr(reg_wr), .o_alu_a_src(alu_a_src),
    .o_alu_b_src(alu_b_src), .o_alu_op(alu_op), .o_mem_to_reg(mem_to_reg),
    .o_mem_wr(mem_wr), .o_mem_op(mem_op), .o_ebreak(ebreak)
  );

  assign wr_ok = !i_rst && !halt; // no state change once halted

  rv_regfile u_regfile (
    .i_clk(i_clk), .i_rst(i_rst), .i_ra(ra), .i_rb(rb), .i_dbg_ra(i_dbg_ra),
    .i_rd(rd), .i_wr_en(reg_wr && wr_ok), .i_wr_data(wb_data),
    .o_rdata_a(rs1), .o_rdata_b(rs2), .o_dbg_rdata(o_dbg_rdata)
  );

  assign alu_a = alu_a_src ? pc : rs1;

  always_comb begin
    case (alu_b_src)
      rv_pkg::BSRC_IMM:  alu_b = imm;
      rv_pkg::BSRC_FOUR: alu_b = 64'd4;
      default:           alu_b = rs2;
    endcase
  end

  rv_alu u_alu (.i_a(alu_a), .i_b(alu_b), .i_op(alu_op), .o_result(alu_result), .o_zero(zero));

  rv_dmem u_dmem (
    .i_clk(i_clk), .i_wr_en(mem_wr && wr_ok), .i_addr(alu_result),
    .i_wdata(rs2), .i_mem_op(mem_op), .o_rdata(load_data)
  );

  assign wb_data = mem_to_reg ? load_data : alu_result;

  rv_pcu u_pcu (
    .i_clk(i_clk), .i_rst(i_rst), .i_branch(branch), .i_imm(imm), .i_rs1(rs1),
    .i_zero(zero), .i_ebreak(ebreak), .o_pc(pc), .o_halt(halt)
  );

  assign o_pc   = pc;
  assign o_halt = halt;

endmodule

//--- tb_clkgen.sv
// 100 ns clock with reset high while i_hold is set and for 4 more cycles after it drops
module tb_clkgen (
  input  logic i_hold,
  output logic o_clk,
  output logic o_rst
);
  timeunit 1ns;
  timeprecision 100ps;

  int rst_cnt = 0;

  initial o_clk = 1'b0;
  always #50 o_clk = ~o_clk;

  // reset edges land 1 ns after the clock
  always @(posedge o_clk) begin
    if (i_hold) begin
      rst_cnt <= #1 0;
    end else if (rst_cnt < 4) begin
      rst_cnt <= #1 rst_cnt + 1;
    end
  end

  assign o_rst = i_hold || (rst_cnt < 4);

endmodule

//--- tb_core.sv
// program is loaded while reset is held, then run to ebreak with a 200 cycle limit
module tb_core;
  timeunit 1ns;
  timeprecision 100ps;

  logic        clk;
  logic        rst;
  logic        hold;
  logic        load_we;
  logic [7:0]  load_addr;
  logic [31:0] load_data;
  logic [4:0]  dbg_ra;
  logic [63:0] dbg_rdata;
  logic [63:0] pc;
  logic        halt;

  string       t_name[$];
  logic [31:0] t_inst[$];
  logic [4:0]  t_rd[$];
  logic [63:0] t_exp[$];
  int          errors = 0;
  int unsigned lcg_state = 58032;

  tb_clkgen u_clkgen (.i_hold(hold), .o_clk(clk), .o_rst(rst));

  rv_core uut (
    .i_clk(clk), .i_rst(rst), .i_load_we(load_we), .i_load_addr(load_addr),
    .i_load_data(load_data), .i_dbg_ra(dbg_ra), .o_dbg_rdata(dbg_rdata),
    .o_pc(pc), .o_halt(halt)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011}; // base is always x0
  endfunction

  // bne only
  function automatic logic [31:0] enc_bne(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic add_row(input string name, input logic [31:0] inst, input logic [4:0] rd,
                         input logic [63:0] exp);
    t_name.push_back(name);
    t_inst.push_back(inst);
    t_rd.push_back(rd);
    t_exp.push_back(exp);
  endtask

  initial begin
    logic [31:0] r;
    logic [19:0] u1;
    logic [19:0] u2;
    logic [11:0] i1;
    logic [63:0] halt_pc;
    int          cycles;

    hold      = 1'b1;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    dbg_ra    = '0;
    r  = lcg_next();
    u1 = r[30:11];
    r  = lcg_next();
    u2 = r[30:11];
    r  = lcg_next();
    i1 = r[27:16];

    // row index times 4 is the pc of each instruction
    add_row("addi_x0", enc_i(12'd5, 5'd0, 3'b000, 5'd0, 7'b0010011), 5'd0, 64'd0);
    add_row("lui", enc_u(u1, 5'd1, 7'b0110111), 5'd1, sext32({u1, 12'b0}));
    add_row("auipc", enc_u(u2, 5'd2, 7'b0010111), 5'd2, 64'd8 + sext32({u2, 12'b0}));
    add_row("addi", enc_i(i1, 5'd0, 3'b000, 5'd3, 7'b0010011), 5'd3, {{52{i1[11]}}, i1});
    add_row("lui_neg", enc_u(20'h80000, 5'd7, 7'b0110111), 5'd7, sext32(32'h80000000));
    add_row("addiw_m1", enc_i(12'hfff, 5'd7, 3'b000, 5'd4, 7'b0011011), 5'd4,
            sext32(32'h80000000 + 32'hffffffff));
    add_row("addiw_wrap", enc_i(12'd1, 5'd4, 3'b000, 5'd5, 7'b0011011), 5'd5,
            sext32(32'h7fffffff + 32'd1));
    add_row("addw_wrap", {7'b0, 5'd4, 5'd4, 3'b000, 5'd6, 7'b0111011}, 5'd6,
            sext32(32'h7fffffff + 32'h7fffffff));
    add_row("sd", enc_s(12'd16, 5'd4, 3'b011), 5'd0, 64'd0);
    add_row("sw_hi", enc_s(12'd20, 5'd5, 3'b010), 5'd0, 64'd0);
    add_row("lw_lo", enc_i(12'd16, 5'd0, 3'b010, 5'd8, 7'b0000011), 5'd8, sext32(32'h7fffffff));
    add_row("lw_hi", enc_i(12'd20, 5'd0, 3'b010, 5'd9, 7'b0000011), 5'd9, sext32(32'h80000000));
    add_row("bne_not", enc_bne(13'd8, 5'd4, 5'd4), 5'd0, 64'd0);
    add_row("bne_fall", enc_i(12'd11, 5'd0, 3'b000, 5'd10, 7'b0010011), 5'd10, 64'd11);
    add_row("bne_taken", enc_bne(13'd8, 5'd5, 5'd4), 5'd0, 64'd0);
    add_row("bne_skip", enc_i(12'd99, 5'd0, 3'b000, 5'd11, 7'b0010011), 5'd11, 64'd0);
    add_row("jal_link", enc_jal(21'd8, 5'd12), 5'd12, 64'd68);
    add_row("jal_skip", enc_i(12'd99, 5'd0, 3'b000, 5'd13, 7'b0010011), 5'd13, 64'd0);
    add_row("auipc_zero", enc_u(20'd0, 5'd14, 7'b0010111), 5'd14, 64'd72);
    // 72 + 13 with bit 0 cleared lands on row 21
    add_row("jalr_link", enc_i(12'd13, 5'd14, 3'b000, 5'd15, 7'b1100111), 5'd15, 64'd80);
    add_row("jalr_skip", enc_i(12'd99, 5'd0, 3'b000, 5'd16, 7'b0010011), 5'd16, 64'd0);
    add_row("jalr_land", enc_i(12'd21, 5'd0, 3'b000, 5'd17, 7'b0010011), 5'd17, 64'd21);
    halt_pc = 64'(4 * t_inst.size());

    @(posedge clk);
    #1;
    if (pc !== 64'd0) begin
      errors++;
      $display("error reset_pc expected %h actual %h", 64'd0, pc);
    end
    if (halt !== 1'b0) begin
      errors++;
      $display("error reset_halt expected %b actual %b", 1'b0, halt);
    end

    foreach (t_inst[i]) begin
      load_we   = 1'b1;
      load_addr = 8'(i);
      load_data = t_inst[i];
      @(posedge clk);
      #1;
    end
    load_addr = 8'(t_inst.size());
    load_data = 32'h00100073; // ebreak
    @(posedge clk);
    #1;
    load_we = 1'b0;
    hold    = 1'b0;

    cycles = 0;
    while (halt !== 1'b1 && cycles < 200) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (halt !== 1'b1) begin
      errors++;
      $display("timeout: the core did not halt within 200 cycles");
    end

    // pc and halt must stay frozen
    for (int k = 0; k <= 5; k++) begin
      if (pc !== halt_pc) begin
        errors++;
        $display("error halt_pc expected %h actual %h", halt_pc, pc);
      end
      if (halt !== 1'b1) begin
        errors++;
        $display("error halt_flag expected %b actual %b", 1'b1, halt);
      end
      @(posedge clk);
      #1;
    end

    foreach (t_rd[i]) begin
      if (t_inst[i][6:0] == 7'b0100011 || t_inst[i][6:0] == 7'b1100011) begin
        continue; // stores and branches write no register
      end
      dbg_ra = t_rd[i];
      @(posedge clk);
      #1;
      if (dbg_rdata !== t_exp[i]) begin
        errors++;
        $display("error %s expected %h actual %h", t_name[i], t_exp[i], dbg_rdata);
      end
    end

    $display("done with %0d errors over %0d table rows", errors, t_rd.size());
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
rv_pkg.sv
rv_alu.sv
rv_idu.sv
rv_regfile.sv
rv_pcu.sv
rv_dmem.sv
rv_imem.sv
rv_core.sv
tb_clkgen.sv
tb_core.sv
